/* source/trace_pkg.sv */
// trace geometry; depth is 2**(aw-1) because address bit 0 picks the record field; dw < 32
`default_nettype none

package trace_pkg;

  localparam int aw = 12;                  // trace window address bits
  localparam int dw = 20;                  // traced data word
  localparam int tw = 24;                  // timestamp delta field
  localparam int depth = 2 ** (aw - 1);    // records in the buffer
  localparam int strobe_bits = 4;          // phase strobes on top of the word

  // data bits that carry the phase strobes
  localparam logic [dw-1:0] strobe_mask = {{strobe_bits{1'b1}}, {(dw - strobe_bits){1'b0}}};

  // strobe k fires for counter nibble 0, 2, 4, 8
  // a record's strobes match this rule applied to (counter field - 1)
  function automatic logic [strobe_bits-1:0] phase_hits(input logic [3:0] nibble);
    return {
      nibble == 4'h8,                      // strobe 3
      nibble == 4'h4,                      // strobe 2
      nibble == 4'h2,                      // strobe 1
      nibble == 4'h0                       // strobe 0
    };
  endfunction

endpackage

`default_nettype wire

/* source/bus_pkg.sv */
// local bus map; windows must be power-of-two sized and aligned, reads settle in read_latency
`default_nettype none

package bus_pkg;

  localparam int bus_aw = 16;               // host address
  localparam int bus_dw = 32;               // host data
  localparam int read_latency = 2;          // address to lb_rdata, address held

  localparam logic [bus_dw-1:0] unmapped_value = 32'hdeadbeef;
  localparam logic [15:0] rom_magic = 16'h7ace;  // ROM word 0

  localparam logic [bus_aw-1:0] trace_base = 16'h0000;   // record readback
  localparam logic [bus_aw-1:0] trace_size = 16'h1000;
  localparam logic [bus_aw-1:0] start_addr = 16'h1000;   // write bit 0 to start
  localparam logic [bus_aw-1:0] running_addr = 16'h1001; // capture state
  localparam logic [bus_aw-1:0] wr_ptr_addr = 16'h1002;  // records written
  localparam logic [bus_aw-1:0] mask_addr = 16'h1003;    // change mask, r/w
  localparam logic [bus_aw-1:0] rom_base = 16'h4000;     // config ROM
  localparam logic [bus_aw-1:0] rom_size = 16'h0800;

  // true when addr falls inside an aligned window
  function automatic logic in_window(input logic [bus_aw-1:0] addr,
                                     input logic [bus_aw-1:0] base,
                                     input logic [bus_aw-1:0] size);
    return (addr & ~(size - 1'b1)) == base;
  endfunction

endpackage

`default_nettype wire

/* source/trace_buffer.sv */
// simple dual-port RAM, one clock, read data valid one cycle after raddr, no reset on contents
`timescale 1ns/100ps
`default_nettype none

module trace_buffer #(
  parameter int addr_w = 11,
  parameter int width = 44
) (
  input  wire              clk,
  input  wire              we,
  input  wire [addr_w-1:0] waddr,
  input  wire [width-1:0]  wdata,
  input  wire [addr_w-1:0] raddr,
  output logic [width-1:0] rdata
);

  logic [width-1:0] mem [0:2**addr_w-1];  // block RAM inferred

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read port, read-before-write on collision
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

/* source/change_trace.sv */
// records masked changes of trace_data with delta; stops after 2**(aw-1) records, start restarts
`timescale 1ns/100ps
`default_nettype none

module change_trace #(
  parameter int aw = 12,
  parameter int dw = 20,
  parameter int tw = 24
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire [dw-1:0]               trace_data,
  input  wire                        start,
  input  wire [dw-1:0]               change_mask,
  output logic                       running,
  output logic [aw-1:0]              wr_ptr,
  input  wire [aw-1:0]               rd_addr,
  output logic [bus_pkg::bus_dw-1:0] trace_rdata
);

  localparam int depth = 2 ** (aw - 1);          // records
  localparam int rw = dw + tw;                   // record word, {delta, data}
  localparam logic [aw-1:0] last_ptr = aw'(depth - 1);

  logic [dw-1:0] prev_data;                      // last cycle's sample
  logic [tw-1:0] delta_cnt;                      // cycles since last record
  logic          first;                          // next record is unconditional
  logic          changed;
  logic          record;
  logic [tw-1:0] rec_delta;

  logic          we_q;                           // write stage, one cycle late
  logic [aw-2:0] waddr_q;
  logic [rw-1:0] wdata_q;

  logic [rw-1:0] rd_word;                        // buffer read data
  logic          half_q;                         // field select, aligned to rd_word

  assign changed = |((trace_data ^ prev_data) & change_mask);  // masked bits only
  assign record = running && !start && (first || changed);     // start wins
  assign rec_delta = first ? '0 : delta_cnt;                   // first record gets 0

  // sample history and write stage payload
  always_ff @(posedge clk) begin
    prev_data <= trace_data;
    wdata_q <= {rec_delta, trace_data};
    waddr_q <= wr_ptr[aw-2:0];
    half_q <= rd_addr[0];
  end

  // capture control
  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      wr_ptr <= '0;
      first <= 1'b0;
      delta_cnt <= '0;
      we_q <= 1'b0;
    end else begin
      we_q <= record;                            // RAM write follows decision
      if (start) begin
        running <= 1'b1;                         // also a restart while running
        wr_ptr <= '0;
        first <= 1'b1;
      end else if (record) begin
        first <= 1'b0;
        wr_ptr <= wr_ptr + 1'b1;
        delta_cnt <= tw'(1);                     // next cycle is one cycle later
        if (wr_ptr == last_ptr) begin
          running <= 1'b0;                       // buffer full, pointer hits depth
        end
      end else if (delta_cnt != '1) begin
        delta_cnt <= delta_cnt + 1'b1;           // saturates at all ones
      end
    end
  end

  trace_buffer #(
    .addr_w(aw - 1),
    .width(rw)
  ) buffer_i (
    .clk(clk),
    .we(we_q),
    .waddr(waddr_q),
    .wdata(wdata_q),
    .raddr(rd_addr[aw-1:1]),                     // bit 0 picks the field
    .rdata(rd_word)
  );

  // field select, zero-extended to the bus
  always_comb begin
    trace_rdata = '0;
    if (half_q) begin
      trace_rdata[tw-1:0] = rd_word[rw-1:dw];    // delta
    end else begin
      trace_rdata[dw-1:0] = rd_word[dw-1:0];     // data word
    end
  end

endmodule

`default_nettype wire

/* source/config_rom.sv */
// geometry ROM for the host, one-cycle registered read; undefined words read 0
`timescale 1ns/100ps
`default_nettype none

module config_rom (
  input  wire        clk,
  input  wire [10:0] address,
  output logic [15:0] data
);

  // word 0 identifies the build, words 1..3 give the trace widths
  localparam logic [15:0] word_magic = bus_pkg::rom_magic;
  localparam logic [15:0] word_aw = 16'(trace_pkg::aw);
  localparam logic [15:0] word_dw = 16'(trace_pkg::dw);
  localparam logic [15:0] word_tw = 16'(trace_pkg::tw);

  logic [15:0] lookup;  // combinational table

  always_comb begin
    case (address)
      11'd0: lookup = word_magic;
      11'd1: lookup = word_aw;       // trace window address bits
      11'd2: lookup = word_dw;       // data word width
      11'd3: lookup = word_tw;       // delta width
      default: lookup = 16'h0000;    // rest of the 2k window
    endcase
  end

  // output register, BRAM-like timing
  always_ff @(posedge clk) begin
    data <= lookup;
  end

endmodule

`default_nettype wire

/* source/pattern_gen.sv */
// test pattern only; counter wraps every 2**(dw-4) cycles, strobe timing fixed to a 4-bit nibble
`timescale 1ns/100ps
`default_nettype none

module pattern_gen #(
  parameter int dw = 20
) (
  input  wire          clk,
  input  wire          reset,
  output logic [dw-1:0] trace_data
);

  localparam int sb = trace_pkg::strobe_bits;  // strobes on top
  localparam int cw = dw - sb;                 // counter below

  logic [cw-1:0] counter;
  logic [sb-1:0] strobes;

  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
      strobes <= '0;
    end else begin
      counter <= counter + 1'b1;                        // changes every cycle
      strobes <= trace_pkg::phase_hits(counter[3:0]);  // one cycle behind the count
    end
  end

  // strobes above the counter
  assign trace_data = {strobes, counter};

endmodule

`default_nettype wire

/* source/trace_host_regs.sv */
// bus decoder; data is valid 2 cycles after a held address, no write handshake, needs dw < 32
`timescale 1ns/100ps
`default_nettype none

module trace_host_regs #(
  parameter int aw = 12,
  parameter int dw = 20
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire [bus_pkg::bus_aw-1:0]  lb_addr,
  input  wire [bus_pkg::bus_dw-1:0]  lb_wdata,
  input  wire                        lb_write,
  output logic [bus_pkg::bus_dw-1:0] lb_rdata,
  output logic                       start,
  output logic [dw-1:0]              change_mask,
  input  wire                        running,
  input  wire [aw-1:0]               wr_ptr,
  input  wire [bus_pkg::bus_dw-1:0]  trace_rdata,
  input  wire [15:0]                 rom_data
);

  logic [bus_pkg::bus_dw-1:0] read_word;  // mux before the output register

  // writes, start is a one-cycle pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      start <= 1'b0;
      change_mask <= '1;                  // every bit counts by default
    end else begin
      start <= lb_write && (lb_addr == bus_pkg::start_addr) && lb_wdata[0];
      if (lb_write && (lb_addr == bus_pkg::mask_addr)) begin
        change_mask <= lb_wdata[dw-1:0];
      end
    end
  end

  // read mux, ROM and trace data already one cycle late
  always_comb begin
    read_word = '0;
    if (bus_pkg::in_window(lb_addr, bus_pkg::rom_base, bus_pkg::rom_size)) begin
      read_word[15:0] = rom_data;
    end else if (bus_pkg::in_window(lb_addr, bus_pkg::trace_base, bus_pkg::trace_size)) begin
      read_word = trace_rdata;            // already zero-extended
    end else if (lb_addr == bus_pkg::running_addr) begin
      read_word[0] = running;
    end else if (lb_addr == bus_pkg::wr_ptr_addr) begin
      read_word[aw-1:0] = wr_ptr;
    end else if (lb_addr == bus_pkg::mask_addr) begin
      read_word[dw-1:0] = change_mask;
    end else begin
      read_word = bus_pkg::unmapped_value;  // includes the write-only start
    end
  end

  // second read stage
  always_ff @(posedge clk) begin
    if (reset) begin
      lb_rdata <= bus_pkg::unmapped_value;
    end else begin
      lb_rdata <= read_word;
    end
  end

endmodule

`default_nettype wire

/* source/trace_top.sv */
// trace subsystem top; local bus exposed directly, reads settle in bus_pkg::read_latency cycles
`timescale 1ns/100ps
`default_nettype none

module trace_top (
  input  wire                       clk,
  input  wire                       reset,
  input  wire [bus_pkg::bus_aw-1:0] lb_addr,
  input  wire [bus_pkg::bus_dw-1:0] lb_wdata,
  input  wire                       lb_write,
  output wire [bus_pkg::bus_dw-1:0] lb_rdata
);

  localparam int aw = trace_pkg::aw;  // geometry, also reported by the ROM
  localparam int dw = trace_pkg::dw;
  localparam int tw = trace_pkg::tw;

  wire [dw-1:0]              trace_data;   // generator to capture
  wire                       start;        // one-cycle pulse
  wire [dw-1:0]              change_mask;  // level from the decoder
  wire                       running;
  wire [aw-1:0]              wr_ptr;
  wire [bus_pkg::bus_dw-1:0] trace_rdata;  // record field, one cycle late
  wire [15:0]                rom_data;     // ROM word, one cycle late

  trace_host_regs #(
    .aw(aw),
    .dw(dw)
  ) trace_host_regs_i (
    .clk(clk),
    .reset(reset),
    .lb_addr(lb_addr),
    .lb_wdata(lb_wdata),
    .lb_write(lb_write),
    .lb_rdata(lb_rdata),
    .start(start),
    .change_mask(change_mask),
    .running(running),
    .wr_ptr(wr_ptr),
    .trace_rdata(trace_rdata),
    .rom_data(rom_data)
  );

  change_trace #(
    .aw(aw),
    .dw(dw),
    .tw(tw)
  ) change_trace_i (
    .clk(clk),
    .reset(reset),
    .trace_data(trace_data),
    .start(start),
    .change_mask(change_mask),
    .running(running),
    .wr_ptr(wr_ptr),
    .rd_addr(lb_addr[aw-1:0]),     // low bits of the trace window
    .trace_rdata(trace_rdata)
  );

  config_rom config_rom_i (
    .clk(clk),
    .address(lb_addr[10:0]),       // 2k-word ROM window
    .data(rom_data)
  );

  pattern_gen #(
    .dw(dw)
  ) pattern_gen_i (
    .clk(clk),
    .reset(reset),
    .trace_data(trace_data)
  );

endmodule

`default_nettype wire

/* testbench/trace_top_props.sv */
// capture engine properties bound into change_trace; aw must match the bound instance, idle in reset
`timescale 1ns/100ps
`default_nettype none

module trace_top_props #(
  parameter int aw = 12
) (
  input wire          clk,
  input wire          reset,
  input wire          start,
  input wire          running,
  input wire [aw-1:0] wr_ptr
);

  localparam logic [aw-1:0] depth_ptr = aw'(2 ** (aw - 1));  // pointer value when full

  // capture only stops on a full buffer
  running_stop: assert property (@(posedge clk) disable iff (reset)
    $fell(running) |-> wr_ptr == depth_ptr)
    else $error("running fell with pointer at %0d", wr_ptr);

  // pointer moves only while capturing or on a start
  pointer_hold: assert property (@(posedge clk) disable iff (reset)
    wr_ptr != $past(wr_ptr) |-> $past(running) || $past(start))
    else $error("pointer moved to %0d while idle", wr_ptr);

  // start clears the pointer one cycle later
  pointer_clear: assert property (@(posedge clk) disable iff (reset)
    start |=> wr_ptr == '0)
    else $error("pointer %0d not cleared after start", wr_ptr);

endmodule

bind change_trace trace_top_props #(
  .aw(aw)
) props_i (
  .clk(clk),
  .reset(reset),
  .start(start),
  .running(running),
  .wr_ptr(wr_ptr)
);

`default_nettype wire

/* testbench/trace_top_tb.sv */
// relies on the built-in counter pattern; inputs change 2 ns after rising edges
`timescale 1ns/100ps
`default_nettype none

module trace_top_tb;

  localparam int depth = trace_pkg::depth;                    // records per capture
  localparam int cw = trace_pkg::dw - trace_pkg::strobe_bits; // counter field bits
  localparam int drive_delay = 2;                             // ns after rising edge
  localparam logic [31:0] full_mask = (32'd1 << trace_pkg::dw) - 32'd1;
  localparam logic [31:0] count_mask = (32'd1 << cw) - 32'd1;

  typedef struct packed {
    logic [15:0] addr;
    logic        write;                   // 1 writes wdata, 0 reads and compares
    logic [31:0] wdata;
    logic [31:0] expected;
  } bus_step_t;

  logic        clk;
  logic        reset;
  logic [15:0] lb_addr;
  logic [31:0] lb_wdata;
  logic        lb_write;
  wire  [31:0] lb_rdata;

  bus_step_t steps[$];                    // register table
  int value_errors = 0;
  int other_errors = 0;
  int cycle_count = 0;
  int timeout_limit = 0;                  // 0 until the table is built

  trace_top trace_top_i (
    .clk(clk),
    .reset(reset),
    .lb_addr(lb_addr),
    .lb_wdata(lb_wdata),
    .lb_write(lb_write),
    .lb_rdata(lb_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;               // 20 ns period
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // watchdog limit scales with table length and two full captures
  initial begin
    while (timeout_limit == 0 || cycle_count < timeout_limit) begin
      @(posedge clk);
    end
    $display("timeout: run did not finish within %0d cycles", timeout_limit);
    $display("Finished with errors");
    $finish;
  end

  task automatic add_step(input logic [15:0] addr, input logic write,
                          input logic [31:0] wdata, input logic [31:0] expected);
    bus_step_t s;
    s.addr = addr;
    s.write = write;
    s.wdata = wdata;
    s.expected = expected;
    steps.push_back(s);
  endtask

  task automatic build_table();
    add_step(bus_pkg::running_addr, 1'b0, 32'd0, 32'd0);      // idle after reset
    add_step(bus_pkg::wr_ptr_addr, 1'b0, 32'd0, 32'd0);
    add_step(bus_pkg::mask_addr, 1'b0, 32'd0, full_mask);     // mask resets to ones
    add_step(16'h2000, 1'b0, 32'd0, bus_pkg::unmapped_value); // holes in the map
    add_step(16'h1004, 1'b0, 32'd0, bus_pkg::unmapped_value);
    add_step(bus_pkg::start_addr, 1'b0, 32'd0, bus_pkg::unmapped_value); // write only
    add_step(bus_pkg::rom_base, 1'b0, 32'd0, 32'(bus_pkg::rom_magic));
    add_step(bus_pkg::rom_base + 16'd1, 1'b0, 32'd0, 32'(trace_pkg::aw));
    add_step(bus_pkg::rom_base + 16'd2, 1'b0, 32'd0, 32'(trace_pkg::dw));
    add_step(bus_pkg::rom_base + 16'd3, 1'b0, 32'd0, 32'(trace_pkg::tw));
    add_step(bus_pkg::rom_base + 16'd100, 1'b0, 32'd0, 32'd0);
    add_step(bus_pkg::start_addr, 1'b1, 32'hfffffffe, 32'd0); // bit 0 clear, no start
    add_step(bus_pkg::running_addr, 1'b0, 32'd0, 32'd0);
    add_step(bus_pkg::mask_addr, 1'b1, 32'hfff5a5a5, 32'd0);
    add_step(bus_pkg::mask_addr, 1'b0, 32'd0, 32'hfff5a5a5 & full_mask); // dw bits kept
    add_step(bus_pkg::mask_addr, 1'b1, full_mask, 32'd0);     // back to all ones
    add_step(bus_pkg::mask_addr, 1'b0, 32'd0, full_mask);
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
    lb_addr = addr;
    lb_wdata = data;
    lb_write = 1'b1;
    @(posedge clk);                        // write lands here
    #drive_delay;
    lb_write = 1'b0;
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [31:0] value);
    lb_addr = addr;
    lb_write = 1'b0;
    repeat (bus_pkg::read_latency) @(posedge clk);
    #drive_delay;
    value = lb_rdata;                      // stable until the next edge
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk);
    #drive_delay;
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  // strobe k follows a counter nibble of 0, 2, 4, 8 by one cycle
  function automatic logic [31:0] expected_strobes(input logic [31:0] count);
    logic [3:0]  prev_nibble;
    logic [31:0] s;
    prev_nibble = count[3:0] - 4'd1;       // count seen one cycle earlier
    s = 32'd0;
    s[0] = (prev_nibble == 4'd0);
    s[1] = (prev_nibble == 4'd2);
    s[2] = (prev_nibble == 4'd4);
    s[3] = (prev_nibble == 4'd8);
    return s;
  endfunction

  function automatic logic [15:0] record_addr(input int index, input int field);
    return bus_pkg::trace_base | 16'((index << 1) | field);  // bit 0 picks the field
  endfunction

  task automatic expect_running(input string phase);
    logic [31:0] state;
    bus_read(bus_pkg::running_addr, state);
    assert (state == 32'd1) else begin
      $display("capture did not start: %s", phase);
      other_errors++;
    end
  endtask

  task automatic wait_capture_done();
    logic [31:0] state;
    state = 32'd1;
    while (state != 32'd0) bus_read(bus_pkg::running_addr, state);
  endtask

  // full readback with per-mode delta and count rules
  task automatic check_records(input logic strobe_mode);
    logic [31:0] data;
    logic [31:0] delta;
    logic [31:0] count;
    logic [31:0] strobes;
    logic [31:0] prev_count;
    logic [31:0] prev_strobes;
    prev_count = 32'd0;
    prev_strobes = 32'd0;
    for (int i = 0; i < depth; i++) begin
      bus_read(record_addr(i, 0), data);
      bus_read(record_addr(i, 1), delta);
      count = data & count_mask;
      strobes = data >> cw;
      check_value(strobes, expected_strobes(count), $sformatf("record %0d strobes", i));
      if (i == 0) begin
        check_value(delta, 32'd0, "first record delta");
      end else if (!strobe_mode) begin
        check_value(delta, 32'd1, $sformatf("record %0d delta", i));
        check_value(count, (prev_count + 32'd1) & count_mask, $sformatf("record %0d count", i));
      end else begin
        assert (strobes != prev_strobes) else begin
          $display("Error at %0t: record %0d strobes unchanged at %h", $time, i, strobes);
          value_errors++;
        end
        check_value(delta, (count - prev_count) & count_mask, $sformatf("record %0d delta", i));
      end
      prev_count = count;
      prev_strobes = strobes;
    end
  endtask

  initial begin
    logic [31:0] got;
    reset = 1'b1;
    lb_addr = 16'h0000;
    lb_wdata = 32'd0;
    lb_write = 1'b0;
    build_table();
    timeout_limit = 3 * (steps.size() * 4 + 2 * depth * 4) + 1000;
    repeat (16) @(posedge clk);
    #drive_delay;
    reset = 1'b0;

    foreach (steps[k]) begin
      if (steps[k].write) begin
        bus_write(steps[k].addr, steps[k].wdata);
      end else begin
        bus_read(steps[k].addr, got);
        check_value(got, steps[k].expected, $sformatf("read of %h", steps[k].addr));
      end
    end

    // every cycle is a change with all mask bits set
    bus_write(bus_pkg::start_addr, 32'd1);
    expect_running("all-ones mask");
    wait_capture_done();
    bus_read(bus_pkg::wr_ptr_addr, got);
    check_value(got, 32'(depth), "pointer after full capture");
    check_records(1'b0);

    // only strobe edges count now
    bus_write(bus_pkg::mask_addr, 32'(trace_pkg::strobe_mask));
    bus_write(bus_pkg::start_addr, 32'd1);
    expect_running("strobe mask");
    wait_capture_done();
    bus_read(bus_pkg::wr_ptr_addr, got);
    check_value(got, 32'(depth), "pointer after strobe capture");
    check_records(1'b1);

    // restart in the middle of a capture
    bus_write(bus_pkg::mask_addr, full_mask);
    bus_write(bus_pkg::start_addr, 32'd1);
    expect_running("before restart");
    idle(20);
    bus_read(bus_pkg::wr_ptr_addr, got);
    assert (got > 32'd1) else begin
      $display("pointer did not advance before the restart");
      other_errors++;
    end
    bus_write(bus_pkg::mask_addr, 32'd0);  // nothing counts as a change
    bus_write(bus_pkg::start_addr, 32'd1);
    expect_running("after restart");
    bus_read(bus_pkg::wr_ptr_addr, got);
    check_value(got, 32'd1, "pointer after restart");
    idle(100);
    bus_read(bus_pkg::wr_ptr_addr, got);
    check_value(got, 32'd1, "pointer with zero mask");
    expect_running("zero mask hold");
    bus_read(record_addr(0, 1), got);
    check_value(got, 32'd0, "restart record delta");
    bus_read(record_addr(0, 0), got);
    check_value(got >> cw, expected_strobes(got & count_mask), "restart record strobes");

    $display("checks done: %0d value errors, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
source/trace_pkg.sv
source/bus_pkg.sv
source/trace_buffer.sv
source/change_trace.sv
source/config_rom.sv
source/pattern_gen.sv
source/trace_host_regs.sv
source/trace_top.sv
testbench/trace_top_props.sv
testbench/trace_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the trace testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module trace_top_tb -f tb.f -o trace_top_tb_sim

output="$(./obj_dir/trace_top_tb_sim)"
echo "$output"

if echo "$output" | grep -q "^Finished with no errors$"; then
  exit 0
fi
exit 1
